// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_sparse_index_decoder
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+verilog
verilog/spmv_cmd_pkg.sv
verilog/spmv_stream_pkg.sv
verilog/pointer_regs.sv
verilog/fetch_timer.sv
verilog/fetch_fsm.sv
verilog/response_buffers.sv
verilog/index_pipeline.sv
verilog/sparse_index_decoder.sv
bench/tb_sparse_index_decoder.sv

// File: bench/index_input.hex
// record: pe_id broadcast stall_en code_base n_code arg_base n_arg remaining n_expected
// then n_code code words, n_arg argument words, n_expected {row, col} words
4
// test 1, direct hit by pe id
0 0 0 1000 8 2000 2 6 7
ABCD000000000F01 09 01 0E 00 11 06 7D
123400000005 FFFFFFFE
0 3 100000000 6 500000000 500000003 50000000B
// test 2, foreign pe id and no broadcast
5 0 0 1000 8 2000 2 6 0
ABCD000000000F01 09 01 0E 00 11 06 7D
123400000005 FFFFFFFE
// test 3, broadcast with random index stall and response delays
5 1 1 10000 8 20008 2 6 7
ABCD000000000F01 09 01 0E 00 11 06 7D
123400000005 FFFFFFFE
0 3 100000000 6 500000000 500000003 50000000B
// test 4, count of 2 stops output after three positions
0 0 0 3000 8 4000 2 2 3
ABCD000000000F01 09 01 0E 00 11 06 7D
123400000005 FFFFFFFE
0 3 100000000

// File: bench/tb_sparse_index_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "spmv_settings.svh"

module tb_sparse_index_decoder
    import spmv_cmd_pkg::*;
    import spmv_stream_pkg::*;
();

    localparam int max_words = 32;
    localparam logic [63:0] idle_cmd = 64'h0fff;

    logic                    clk;
    logic                    rst;
    cmd_word_u               op;
    logic                    req_mem_stall;
    logic                    rsp_mem_push;
    stream_tag_e             rsp_mem_tag;
    logic [63:0]             rsp_mem_q;
    logic                    stall_index;
    logic                    busy;
    logic                    req_mem_ld;
    logic [`SPMV_ADDR_W-1:0] req_mem_addr;
    stream_tag_e             req_mem_tag;
    logic                    rsp_mem_stall;
    logic                    push_index;
    logic [31:0]             row;
    logic [31:0]             col;

    logic [63:0] stim [0:255];
    logic [63:0] code_w [max_words];
    logic [63:0] arg_w [max_words];
    logic [63:0] exp_w [max_words];
    bit          code_seen [max_words];
    bit          arg_seen [max_words];
    logic [63:0] code_q [$];
    int          code_due [$];
    logic [63:0] arg_q [$];
    int          arg_due [$];
    logic [47:0] code_base;
    logic [47:0] arg_base;
    logic [47:0] remaining;
    logic [7:0]  pe;
    logic        bc;
    logic        stall_en;
    logic        stall_prev;
    logic [31:0] lfsr;
    int          n_code;
    int          n_arg;
    int          n_exp;
    int          pushes;
    int          requests;
    int          cycle;
    int          errors;
    int          tests_run;
    int          tests_failed;

    sparse_index_decoder UUT (
        .clk, .rst, .op, .busy, .req_mem_ld, .req_mem_addr, .req_mem_tag,
        .req_mem_stall, .rsp_mem_push, .rsp_mem_tag, .rsp_mem_q, .rsp_mem_stall,
        .push_index, .row, .col, .stall_index
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic cmd_word_u make_cmd(input cmd_opcode_e opc, input reg_index_e idx,
                                           input logic [47:0] value);
        cmd_word_u w;
        w = '0;
        w.load.hdr.opcode = opc;
        w.load.hdr.pe_id = pe;
        w.load.hdr.broadcast = bc;
        w.load.index = idx;
        w.load.value = value[42:0];
        return w;
    endfunction

    // address must be aligned, inside its stream and asked for once
    task automatic take_request();
        logic [47:0] base;
        logic [47:0] off;
        int          count;
        int          idx;
        int          delay;
        base = (req_mem_tag == TAG_CODE) ? code_base : arg_base;
        count = (req_mem_tag == TAG_CODE) ? n_code : n_arg;
        off = req_mem_addr - base;
        requests++;
        if (req_mem_addr < base || off >= 48'(8 * count) || off[2:0] != 3'd0) begin
            $display("request address %h with tag %0d outside its loaded range",
                     req_mem_addr, req_mem_tag);
            errors++;
            return;
        end
        idx = int'(off >> 3);
        delay = 3;
        if (stall_en) begin
            take_bits(3, delay);
            delay = delay + 2;
        end
        if (req_mem_tag == TAG_CODE) begin
            if (code_seen[idx]) begin
                $display("code address %h requested twice", req_mem_addr);
                errors++;
            end
            code_seen[idx] = 1'b1;
            code_q.push_back(code_w[idx]);
            code_due.push_back(cycle + delay);
        end else begin
            if (arg_seen[idx]) begin
                $display("argument address %h requested twice", req_mem_addr);
                errors++;
            end
            arg_seen[idx] = 1'b1;
            arg_q.push_back(arg_w[idx]);
            arg_due.push_back(cycle + delay);
        end
    endtask

    task automatic check_push();
        logic [31:0] exp_row;
        logic [31:0] exp_col;
        if (pushes >= n_exp) begin
            $display("push %0d arrived beyond the %0d expected positions", pushes + 1, n_exp);
            errors++;
        end else begin
            exp_row = exp_w[pushes][63:32];
            exp_col = exp_w[pushes][31:0];
            if (row !== exp_row) begin
                $display("ERR row push %0d expected %h got %h", pushes, exp_row, row);
                errors++;
            end
            if (col !== exp_col) begin
                $display("ERR col push %0d expected %h got %h", pushes, exp_col, col);
                errors++;
            end
        end
        pushes++;
    endtask

    // sample outputs each clock and then drive memory responses and the index stall
    task automatic tick();
        int b;
        @(posedge clk);
        #1;
        cycle++;
        if (req_mem_ld === 1'b1)
            take_request();
        if (push_index === 1'b1)
            check_push();
        rsp_mem_push = 1'b0;
        // one tag head per cycle and in order within each tag
        if (!stall_prev) begin
            if (code_q.size() > 0 && code_due[0] <= cycle) begin
                rsp_mem_push = 1'b1;
                rsp_mem_tag = TAG_CODE;
                rsp_mem_q = code_q.pop_front();
                void'(code_due.pop_front());
            end else if (arg_q.size() > 0 && arg_due[0] <= cycle) begin
                rsp_mem_push = 1'b1;
                rsp_mem_tag = TAG_ARG;
                rsp_mem_q = arg_q.pop_front();
                void'(arg_due.pop_front());
            end
        end
        stall_prev = rsp_mem_stall;
        stall_index = 1'b0;
        if (stall_en) begin
            take_bits(2, b);
            stall_index = (b == 3);
        end
    endtask

    task automatic send_cmd(input cmd_word_u w);
        op = w;
        tick();
        op = idle_cmd;
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int n;
        n = 0;
        while (busy !== level && n < limit) begin
            tick();
            n++;
        end
        if (busy !== level) begin
            $display("timeout, busy did not reach %0d within %0d cycles", level, limit);
            errors++;
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (code_q.size() + arg_q.size() > 0 && n < limit) begin
            tick();
            n++;
        end
        if (code_q.size() + arg_q.size() > 0) begin
            $display("timeout, memory responses still pending after %0d cycles", limit);
            errors++;
        end
        // let the pipeline empty
        repeat (20) tick();
    endtask

    task automatic report(input int num, input int err_start, input string what);
        tests_run++;
        if (errors == err_start) begin
            $display("test %0d %s ok", num, what);
        end else begin
            $display("test %0d %s failed with %0d errors", num, what, errors - err_start);
            tests_failed++;
        end
    endtask

    task automatic check_reset();
        int err_start;
        err_start = errors;
        repeat (20) begin
            tick();
            if (busy !== 1'b0 || req_mem_ld !== 1'b0 || push_index !== 1'b0
                    || rsp_mem_stall !== 1'b0) begin
                $display("ERR busy %h req_mem_ld %h push_index %h rsp_mem_stall %h expected 0",
                         busy, req_mem_ld, push_index, rsp_mem_stall);
                errors++;
            end
        end
        if (row !== 32'h3) begin
            $display("ERR row expected %h got %h", 32'h3, row);
            errors++;
        end
        if (col !== 32'hffff_ffff) begin
            $display("ERR col expected %h got %h", 32'hffff_ffff, col);
            errors++;
        end
        report(0, err_start, "reset state");
    endtask

    task automatic load_test(inout int rp);
        pe = stim[rp][7:0];
        bc = stim[rp + 1][0];
        stall_en = stim[rp + 2][0];
        code_base = stim[rp + 3][47:0];
        n_code = int'(stim[rp + 4]);
        arg_base = stim[rp + 5][47:0];
        n_arg = int'(stim[rp + 6]);
        remaining = stim[rp + 7][47:0];
        n_exp = int'(stim[rp + 8]);
        rp = rp + 9;
        for (int i = 0; i < n_code; i++)
            code_w[i] = stim[rp + i];
        rp = rp + n_code;
        for (int i = 0; i < n_arg; i++)
            arg_w[i] = stim[rp + i];
        rp = rp + n_arg;
        for (int i = 0; i < n_exp; i++)
            exp_w[i] = stim[rp + i];
        rp = rp + n_exp;
        foreach (code_seen[i]) code_seen[i] = 1'b0;
        foreach (arg_seen[i]) arg_seen[i] = 1'b0;
        pushes = 0;
        requests = 0;
    endtask

    task automatic run_test(input int num);
        int   err_start;
        logic hit;
        err_start = errors;
        // decoder_id is left at 0
        hit = bc || pe == 8'd0;
        send_cmd(make_cmd(OP_LD, R_CODE_PTR, code_base));
        send_cmd(make_cmd(OP_LD, R_ARG_PTR, arg_base));
        send_cmd(make_cmd(OP_LD, R_CODE_END, code_base + 48'(8 * n_code)));
        send_cmd(make_cmd(OP_LD, R_ARG_END, arg_base + 48'(8 * n_arg)));
        send_cmd(make_cmd(OP_LD, R_REMAINING, remaining));
        send_cmd(make_cmd(OP_STEADY, R_CODE_PTR, '0));
        if (hit) begin
            wait_busy(1'b1, 10);
            wait_busy(1'b0, 5000);
            if (requests != n_code + n_arg) begin
                $display("%0d requests before busy fell, %0d words loaded",
                         requests, n_code + n_arg);
                errors++;
            end
            wait_drain(2000);
        end else begin
            repeat (20) begin
                tick();
                if (busy !== 1'b0) begin
                    $display("ERR busy expected %h got %h", 1'b0, busy);
                    errors++;
                end
            end
            if (requests != 0) begin
                $display("%0d requests issued for a foreign command", requests);
                errors++;
            end
        end
        if (pushes != n_exp) begin
            $display("ERR push_index count expected %h got %h", n_exp, pushes);
            errors++;
        end
        pe = 8'hff;
        bc = 1'b1;
        send_cmd(make_cmd(OP_RST, R_CODE_PTR, '0));
        repeat (4) tick();
        report(num, err_start, hit ? "run" : "foreign target");
    endtask

    initial begin
        int rp;
        int n_tests;
        rst = 1'b1;
        op = idle_cmd;
        req_mem_stall = 1'b0;
        rsp_mem_push = 1'b0;
        rsp_mem_tag = TAG_CODE;
        rsp_mem_q = '0;
        stall_index = 1'b0;
        stall_en = 1'b0;
        stall_prev = 1'b0;
        lfsr = 32'd51;
        code_base = '0;
        arg_base = '0;
        n_code = 0;
        n_arg = 0;
        n_exp = 0;
        pushes = 0;
        requests = 0;
        cycle = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        $readmemh("bench/index_input.hex", stim);
        repeat (10) tick();
        rst = 1'b0;
        check_reset();
        n_tests = int'(stim[0]);
        rp = 1;
        for (int t = 1; t <= n_tests; t++) begin
            load_test(rp);
            run_test(t);
        end
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/fetch_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "spmv_settings.svh"

module fetch_fsm
    import spmv_cmd_pkg::*;
    import spmv_stream_pkg::*;
#(
    parameter logic [7:0] decoder_id = 8'd0
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire cmd_word_u           op,
    input  wire run_ptrs_t           ptrs,
    input  wire                      switch_tick,
    input  wire                      in_flight_ok,
    input  wire                      req_mem_stall,
    output logic                     cmd_hit,
    output logic                     busy,
    output logic                     req_mem_ld,
    output logic [`SPMV_ADDR_W-1:0]  req_mem_addr,
    output stream_tag_e              req_mem_tag,
    output logic                     code_step,
    output logic                     arg_step,
    output logic                     decoder_rst
);

    localparam int addr_w = `SPMV_ADDR_W;

    typedef enum logic [1:0] {IDLE, FETCH_CODES, FETCH_ARGS} fetch_state_e;

    fetch_state_e      state;
    fetch_state_e      next_state;
    logic              stall_q;
    logic              next_ld;
    logic [addr_w-1:0] next_addr;
    stream_tag_e       next_tag;
    logic              code_left;
    logic              arg_left;
    logic              run_done;

    assign cmd_hit = op.ctrl.hdr.broadcast || (op.ctrl.hdr.pe_id == decoder_id);
    assign code_left = ptrs.code_ptr != ptrs.code_end;
    assign arg_left = ptrs.arg_ptr != ptrs.arg_end;
    // both streams fetched and the count has run out
    assign run_done = !code_left && !arg_left && ptrs.remaining[addr_w-1];
    assign busy = state != IDLE;

    always_comb begin
        next_state = state;
        next_ld = 1'b0;
        next_addr = ptrs.code_ptr;
        next_tag = TAG_CODE;
        code_step = 1'b0;
        arg_step = 1'b0;
        case (state)
            FETCH_CODES: begin
                if (code_left && !stall_q && in_flight_ok) begin
                    next_ld = 1'b1;
                    code_step = 1'b1;
                end
                if (switch_tick || !in_flight_ok || !code_left)
                    next_state = FETCH_ARGS;
            end
            FETCH_ARGS: begin
                next_addr = ptrs.arg_ptr;
                next_tag = TAG_ARG;
                if (arg_left && !stall_q && in_flight_ok) begin
                    next_ld = 1'b1;
                    arg_step = 1'b1;
                end
                if (switch_tick || !in_flight_ok || !arg_left)
                    next_state = FETCH_CODES;
            end
            default: ;
        endcase
        if (state != IDLE && run_done)
            next_state = IDLE;
        if (cmd_hit && op.ctrl.hdr.opcode == OP_RST)
            next_state = IDLE;
        if (cmd_hit && op.ctrl.hdr.opcode == OP_STEADY)
            next_state = FETCH_CODES;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            stall_q <= 1'b0;
            req_mem_ld <= 1'b0;
            decoder_rst <= 1'b0;
        end else begin
            state <= next_state;
            stall_q <= req_mem_stall;
            req_mem_ld <= next_ld;
            decoder_rst <= cmd_hit && op.ctrl.hdr.opcode == OP_RST;
        end
    end

    always_ff @(posedge clk) begin
        req_mem_addr <= next_addr;
        req_mem_tag <= next_tag;
    end

endmodule

`default_nettype wire

// File: verilog/fetch_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "spmv_settings.svh"

module fetch_timer (
    input  wire       clk,
    input  wire       rst,
    input  wire       req_issued,
    input  wire [1:0] word_released,
    output logic      switch_tick,
    output logic      in_flight_ok
);

    localparam int period = `SPMV_SWITCH_PERIOD;
    localparam int tmr_w = $clog2(period);
    localparam int depth = `SPMV_BUF_DEPTH;
    localparam int cnt_w = $clog2(2 * depth + 1);
    localparam logic [cnt_w-1:0] limit = cnt_w'(2 * depth - `SPMV_BUF_ALMOST_FULL);

    logic [tmr_w-1:0] timer;
    logic [cnt_w-1:0] outstanding;

    assign switch_tick = timer == tmr_w'(period - 1);
    // issue check lags one request behind, the buffer stall covers it
    assign in_flight_ok = outstanding < limit;

    always_ff @(posedge clk) begin
        if (rst) begin
            timer <= '0;
            outstanding <= '0;
        end else begin
            timer <= switch_tick ? '0 : timer + 1'b1;
            outstanding <= outstanding + cnt_w'(req_issued) - cnt_w'(word_released);
        end
    end

endmodule

`default_nettype wire

// File: verilog/index_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "spmv_settings.svh"

module index_pipeline
    import spmv_stream_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire code_entry_t        code_head,
    input  wire                     code_valid,
    input  wire [`SPMV_POS_W-1:0]   arg_head,
    input  wire                     arg_valid,
    input  wire                     stall_index,
    input  wire                     remaining_neg,
    output logic                    code_pop,
    output logic                    arg_pop,
    output logic                    emitted,
    output logic                    push_index,
    output logic [`SPMV_POS_W-1:0]  row,
    output logic [`SPMV_POS_W-1:0]  col
);

    localparam int pos_w = `SPMV_POS_W;
    localparam int sw = `SPMV_LOG2_SUB_W;
    localparam int sh = `SPMV_LOG2_SUB_H;
    localparam int hi_w = pos_w - sw;
    // one step before the first cell of the first tile row
    localparam grid_pos_t pos_init = '{row: pos_w'((1 << sh) - 1), col: {pos_w{1'b1}}};

    logic             is_range;
    logic [pos_w-1:0] bit_at;
    logic [pos_w-1:0] step;
    logic             s1_valid;
    logic             s1_newline;
    logic [pos_w-1:0] s1_step;
    grid_pos_t        pos;
    grid_pos_t        next_pos;
    grid_pos_t        out_pos;
    logic [sw:0]      col_lo;
    logic [sh:0]      row_lo;
    logic [hi_w-1:0]  col_hi;

    // stage 0, pop and step
    assign is_range = code_head.kind == CODE_RANGE;
    assign code_pop = code_valid && !stall_index && (!is_range || arg_valid);
    assign arg_pop = code_pop && is_range;
    assign bit_at = pos_w'(1) << code_head.delta;
    // range step keeps delta low bits of the argument under an implied top bit
    assign step = is_range ? ((arg_head & (bit_at - 1'b1)) | bit_at) + 1'b1
                           : pos_w'(code_head.delta) + 1'b1;

    always_ff @(posedge clk) begin
        if (rst)
            s1_valid <= 1'b0;
        else
            s1_valid <= code_pop;
    end

    always_ff @(posedge clk) begin
        s1_step <= step;
        s1_newline <= code_head.kind == CODE_NEWLINE;
    end

    // mixed radix add over {col high, row low, col low}
    always_comb begin
        col_lo = {1'b0, pos.col[sw-1:0]} + {1'b0, s1_step[sw-1:0]};
        row_lo = {1'b0, pos.row[sh-1:0]} + {1'b0, s1_step[sw+sh-1:sw]} + {{sh{1'b0}}, col_lo[sw]};
        col_hi = pos.col[pos_w-1:sw] + hi_w'(s1_step[pos_w-1:sw+sh]) + hi_w'(row_lo[sh]);
        next_pos.row = {pos.row[pos_w-1:sh], row_lo[sh-1:0]};
        next_pos.col = {col_hi, col_lo[sw-1:0]};
        if (s1_newline) begin
            next_pos.row = {pos.row[pos_w-1:sh] + 1'b1, {sh{1'b1}}};
            next_pos.col = '1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pos <= pos_init;
            emitted <= 1'b0;
        end else begin
            emitted <= s1_valid && !s1_newline;
            if (s1_valid)
                pos <= next_pos;
        end
    end

    // output stage, count checked before its decrement lands
    always_ff @(posedge clk) begin
        if (rst) begin
            push_index <= 1'b0;
            out_pos <= pos_init;
        end else begin
            push_index <= emitted && !remaining_neg;
            out_pos <= pos;
        end
    end

    assign row = out_pos.row;
    assign col = out_pos.col;

endmodule

`default_nettype wire

// File: verilog/pointer_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "spmv_settings.svh"

module pointer_regs
    import spmv_cmd_pkg::*;
    import spmv_stream_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  wire       cmd_word_u op,
    input  wire       cmd_hit,
    input  wire       code_step,
    input  wire       arg_step,
    input  wire       emitted,
    output run_ptrs_t ptrs
);

    localparam int addr_w = `SPMV_ADDR_W;
    localparam int value_w = $bits(op.load.value);

    logic [addr_w-1:0] load_value;

    // load value is zero extended to the register width
    assign load_value = {{(addr_w - value_w){1'b0}}, op.load.value};

    always_ff @(posedge clk) begin
        if (rst) begin
            ptrs <= '0;
        end else begin
            // one 8-byte word per issued request
            if (code_step)
                ptrs.code_ptr <= ptrs.code_ptr + addr_w'(8);
            if (arg_step)
                ptrs.arg_ptr <= ptrs.arg_ptr + addr_w'(8);
            if (emitted)
                ptrs.remaining <= ptrs.remaining - 1'b1;
            // a load wins over stepping in the same cycle
            if (cmd_hit && op.load.hdr.opcode == OP_LD) begin
                case (op.load.index)
                    R_CODE_PTR:  ptrs.code_ptr <= load_value;
                    R_ARG_PTR:   ptrs.arg_ptr <= load_value;
                    R_CODE_END:  ptrs.code_end <= load_value;
                    R_ARG_END:   ptrs.arg_end <= load_value;
                    R_REMAINING: ptrs.remaining <= load_value;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/response_buffers.sv
`timescale 1ns/1ps
`default_nettype none

`include "spmv_settings.svh"

module response_buffers
    import spmv_stream_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     rsp_mem_push,
    input  wire stream_tag_e        rsp_mem_tag,
    input  wire [`SPMV_WORD_W-1:0]  rsp_mem_q,
    input  wire                     code_pop,
    input  wire                     arg_pop,
    output code_entry_t             code_head,
    output logic                    code_valid,
    output logic [`SPMV_POS_W-1:0]  arg_head,
    output logic                    arg_valid,
    output logic                    rsp_mem_stall,
    output logic [1:0]              word_released
);

    localparam int depth = `SPMV_BUF_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam logic [ptr_w:0] af_level = (ptr_w + 1)'(depth - `SPMV_BUF_ALMOST_FULL);

    // lane 0 holds code entries, lane 1 holds arguments
    for (genvar t = 0; t < 2; t++) begin : lane
        localparam int width = (t == 0) ? $bits(code_entry_t) : `SPMV_POS_W;
        localparam stream_tag_e tag = stream_tag_e'(t);

        logic [width-1:0] mem [depth];
        logic [ptr_w-1:0] wr_ptr;
        logic [ptr_w-1:0] rd_ptr;
        logic [ptr_w:0]   count;
        logic             push;
        logic             pop;
        logic [width-1:0] head;
        logic             almost_full;

        assign push = rsp_mem_push && rsp_mem_tag == tag;
        assign pop = (t == 0) ? code_pop : arg_pop;
        // fall-through head, readable the cycle after the push
        assign head = mem[rd_ptr];
        assign almost_full = count >= af_level;

        always_ff @(posedge clk) begin
            if (push)
                mem[wr_ptr] <= rsp_mem_q[width-1:0];
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count <= '0;
            end else begin
                if (push)
                    wr_ptr <= wr_ptr + 1'b1;
                if (pop)
                    rd_ptr <= rd_ptr + 1'b1;
                count <= count + (ptr_w + 1)'(push) - (ptr_w + 1)'(pop);
            end
        end
    end

    assign code_head = code_entry_t'(lane[0].head);
    assign code_valid = lane[0].count != '0;
    assign arg_head = lane[1].head;
    assign arg_valid = lane[1].count != '0;
    // a range entry releases two words at once
    assign word_released = {1'b0, code_pop} + {1'b0, arg_pop};

    always_ff @(posedge clk) begin
        if (rst)
            rsp_mem_stall <= 1'b0;
        else
            rsp_mem_stall <= lane[0].almost_full || lane[1].almost_full;
    end

endmodule

`default_nettype wire

// File: verilog/sparse_index_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "spmv_settings.svh"

module sparse_index_decoder
    import spmv_cmd_pkg::*;
    import spmv_stream_pkg::*;
#(
    parameter logic [7:0] decoder_id = 8'd0
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire cmd_word_u          op,
    output logic                    busy,
    output logic                    req_mem_ld,
    output logic [`SPMV_ADDR_W-1:0] req_mem_addr,
    output stream_tag_e             req_mem_tag,
    input  wire                     req_mem_stall,
    input  wire                     rsp_mem_push,
    input  wire stream_tag_e        rsp_mem_tag,
    input  wire [`SPMV_WORD_W-1:0]  rsp_mem_q,
    output logic                    rsp_mem_stall,
    output logic                    push_index,
    output logic [`SPMV_POS_W-1:0]  row,
    output logic [`SPMV_POS_W-1:0]  col,
    input  wire                     stall_index
);

    run_ptrs_t              ptrs;
    code_entry_t            code_head;
    logic [`SPMV_POS_W-1:0] arg_head;
    logic                   cmd_hit;
    logic                   code_step;
    logic                   arg_step;
    logic                   emitted;
    logic                   switch_tick;
    logic                   in_flight_ok;
    logic                   decoder_rst;
    logic                   code_valid;
    logic                   arg_valid;
    logic                   code_pop;
    logic                   arg_pop;
    logic [1:0]             word_released;
    logic                   unit_rst;
    logic                   remaining_neg;

    // OP_RST clears the datapath but keeps the loaded registers
    assign unit_rst = rst || decoder_rst;
    assign remaining_neg = ptrs.remaining[`SPMV_ADDR_W-1];

    pointer_regs regs (
        .clk, .rst, .op, .cmd_hit, .code_step, .arg_step, .emitted, .ptrs
    );

    fetch_timer timer (
        .clk, .rst(unit_rst), .req_issued(req_mem_ld), .word_released,
        .switch_tick, .in_flight_ok
    );

    fetch_fsm #(.decoder_id(decoder_id)) fsm (
        .clk, .rst, .op, .ptrs, .switch_tick, .in_flight_ok, .req_mem_stall,
        .cmd_hit, .busy, .req_mem_ld, .req_mem_addr, .req_mem_tag,
        .code_step, .arg_step, .decoder_rst
    );

    response_buffers bufs (
        .clk, .rst(unit_rst), .rsp_mem_push, .rsp_mem_tag, .rsp_mem_q,
        .code_pop, .arg_pop, .code_head, .code_valid, .arg_head, .arg_valid,
        .rsp_mem_stall, .word_released
    );

    index_pipeline pipe (
        .clk, .rst(unit_rst), .code_head, .code_valid, .arg_head, .arg_valid,
        .stall_index, .remaining_neg, .code_pop, .arg_pop, .emitted,
        .push_index, .row, .col
    );

endmodule

`default_nettype wire

// File: verilog/spmv_cmd_pkg.sv
`default_nettype none

package spmv_cmd_pkg;

    `include "spmv_settings.svh"

    typedef enum logic [3:0] {
        OP_RST    = 4'd0,
        OP_LD     = 4'd1,
        OP_STEADY = 4'd2
    } cmd_opcode_e;

    // run registers addressed by OP_LD
    typedef enum logic [7:0] {
        R_CODE_PTR  = 8'd0,
        R_ARG_PTR   = 8'd1,
        R_CODE_END  = 8'd2,
        R_ARG_END   = 8'd3,
        R_REMAINING = 8'd4
    } reg_index_e;

    // low 13 bits of every command
    typedef struct packed {
        logic        broadcast;
        logic [7:0]  pe_id;
        cmd_opcode_e opcode;
    } cmd_header_t;

    typedef struct packed {
        logic [`SPMV_WORD_W-$bits(cmd_header_t)-1:0] unused;
        cmd_header_t hdr;
    } cmd_ctrl_t;

    typedef struct packed {
        logic [`SPMV_WORD_W-$bits(cmd_header_t)-9:0] value;
        reg_index_e  index;
        cmd_header_t hdr;
    } cmd_load_t;

    // same word, seen as a control command or as a register load
    typedef union packed {
        cmd_ctrl_t ctrl;
        cmd_load_t load;
    } cmd_word_u;

endpackage

`default_nettype wire

// File: verilog/spmv_settings.svh
`ifndef SPMV_SETTINGS_SVH
`define SPMV_SETTINGS_SVH

// memory side
`define SPMV_ADDR_W 48
`define SPMV_WORD_W 64
`define SPMV_TAG_W 1

// response buffering, per tag
`define SPMV_BUF_DEPTH 16
// free entries left when the memory stall rises
`define SPMV_BUF_ALMOST_FULL 4

// cycles between forced stream switches
`define SPMV_SWITCH_PERIOD 32

// tile geometry, log2 of width and height
`define SPMV_LOG2_SUB_W 2
`define SPMV_LOG2_SUB_H 2

// row and column width, also the argument width
`define SPMV_POS_W 32

`endif

// File: verilog/spmv_stream_pkg.sv
`default_nettype none

package spmv_stream_pkg;

    `include "spmv_settings.svh"

    typedef enum logic [`SPMV_TAG_W-1:0] {
        TAG_CODE = 1'b0,
        TAG_ARG  = 1'b1
    } stream_tag_e;

    typedef enum logic [1:0] {
        CODE_NEWLINE  = 2'd0,
        CODE_CONSTANT = 2'd1,
        CODE_RANGE    = 2'd2
    } code_kind_e;

    // one entry per code word, kind in the low bits
    typedef struct packed {
        logic [4:0] delta;
        code_kind_e kind;
    } code_entry_t;

    typedef struct packed {
        logic [`SPMV_POS_W-1:0] row;
        logic [`SPMV_POS_W-1:0] col;
    } grid_pos_t;

    typedef struct packed {
        logic [`SPMV_ADDR_W-1:0] code_ptr;
        logic [`SPMV_ADDR_W-1:0] arg_ptr;
        logic [`SPMV_ADDR_W-1:0] code_end;
        logic [`SPMV_ADDR_W-1:0] arg_end;
        logic [`SPMV_ADDR_W-1:0] remaining;
    } run_ptrs_t;

endpackage

`default_nettype wire
